// ==== source/cart_mem_pkg.sv ====
`default_nettype none

package cart_mem_pkg;

   ////////////////////
   // SRAM geometry
   ////////////////////

   // 1M x 16 word array, byte addressed from the cartridge side
   localparam int SRAM_WORD_AW = 20;
   localparam int SRAM_BYTE_AW = 21;

   // Save RAM sits in the top 32 KB of the byte space
   localparam logic [SRAM_BYTE_AW-1:0] SAVE_BASE = 21'h1F8000;

   ////////////////////
   // Enumerations
   ////////////////////

   typedef enum logic {
      MAP_LOROM = 1'b0,
      MAP_HIROM = 1'b1
   } map_mode_e;

   typedef enum logic [1:0] {
      REG_NONE = 2'd0,
      REG_ROM  = 2'd1,
      REG_SAVE = 2'd2
   } region_e;

   typedef enum logic [2:0] {
      S_IDLE       = 3'd0,
      S_SNES_RD    = 3'd1,
      S_SNES_LATCH = 3'd2,
      S_SNES_WR    = 3'd3,
      S_MCU_RD     = 3'd4,
      S_MCU_WR     = 3'd5,
      S_DONE       = 3'd6
   } seq_state_e;

   ////////////////////
   // Bus structs
   ////////////////////

   // SNES cartridge bus, strobes active high
   typedef struct packed {
      logic [23:0] addr;
      logic        rd;
      logic        wr;
      logic [7:0]  data;
   } snes_bus_in_t;

   typedef struct packed {
      logic [7:0] data;
      logic       oe;
   } snes_bus_out_t;

   typedef struct packed {
      logic [SRAM_WORD_AW-1:0] word_addr;
      logic [15:0]             wdata;
      logic [1:0]              be;
      logic                    we;
   } sram_req_t;

   // Strobes into the byte lane registers
   typedef struct packed {
      logic snes_capture;
      logic mcu_capture;
      logic sram_to_snes;
      logic sram_to_mcu;
      logic byte_sel;
      logic src_mcu;
   } lane_ctrl_t;

endpackage

`default_nettype wire

// ==== source/mcu_reg_pkg.sv ====
`default_nettype none

package mcu_reg_pkg;

   ////////////////////
   // AXI4-Lite channels
   ////////////////////

   typedef struct packed {
      logic [3:0]  awaddr;
      logic        awvalid;
      logic [31:0] wdata;
      logic        wvalid;
      logic        bready;
      logic [3:0]  araddr;
      logic        arvalid;
      logic        rready;
   } axil_req_t;

   typedef struct packed {
      logic        awready;
      logic        wready;
      logic        bvalid;
      logic [1:0]  bresp;
      logic        arready;
      logic        rvalid;
      logic [31:0] rdata;
      logic [1:0]  rresp;
   } axil_resp_t;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   // Register map
   localparam logic [3:0] REG_ADDR = 4'h0;
   localparam logic [3:0] REG_DATA = 4'h4;
   localparam logic [3:0] REG_CMD  = 4'h8;
   localparam logic [3:0] REG_CTRL = 4'hC;

   typedef enum logic [7:0] {
      CMD_NOP   = 8'd0,
      CMD_READ  = 8'd1,
      CMD_WRITE = 8'd2
   } mcu_cmd_e;

   // One byte access handed to the sequencer
   typedef struct packed {
      logic        valid;
      logic        is_write;
      logic [20:0] addr;
   } mcu_op_t;

endpackage

`default_nettype wire

// ==== source/snes_addr_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module snes_addr_map (
   input  wire logic [23:0]                            addr,
   input  wire cart_mem_pkg::map_mode_e                mode,
   output logic [cart_mem_pkg::SRAM_BYTE_AW-1:0]       byte_addr,
   output cart_mem_pkg::region_e                       region
);

   logic [7:0]  bank;
   logic        lo_save_bank;
   logic        hi_save_bank;
   logic        hi_save_window;
   logic        hi_rom_bank;

   assign bank = addr[23:16];

   // Bank decodes for both modes
   assign lo_save_bank   = (bank >= 8'h70) && (bank <= 8'h7D);
   assign hi_save_bank   = (bank >= 8'h20) && (bank <= 8'h3F);
   assign hi_save_window = (addr[15:0] >= 16'h6000) && (addr[15:0] <= 16'h7FFF);
   assign hi_rom_bank    = (bank >= 8'hC0);

   always_comb begin
      byte_addr = '0;
      region    = cart_mem_pkg::REG_NONE;
      if (mode == cart_mem_pkg::MAP_LOROM) begin
         // 32 KB pages in the upper half of each bank
         if (lo_save_bank && !addr[15]) begin
            byte_addr = cart_mem_pkg::SAVE_BASE + {6'd0, addr[14:0]};
            region    = cart_mem_pkg::REG_SAVE;
         end else if (addr[15]) begin
            byte_addr = {bank[5:0], addr[14:0]};
            region    = cart_mem_pkg::REG_ROM;
         end
      end else begin
         // 8 KB save window, full 64 KB ROM banks up high
         if (hi_save_bank && hi_save_window) begin
            byte_addr = cart_mem_pkg::SAVE_BASE + {8'd0, addr[12:0]};
            region    = cart_mem_pkg::REG_SAVE;
         end else if (hi_rom_bank) begin
            byte_addr = {bank[4:0], addr[15:0]};
            region    = cart_mem_pkg::REG_ROM;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/byte_lane_data.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_lane_data (
   input  wire logic                     CLK,
   input  wire logic                     reset,
   input  wire cart_mem_pkg::lane_ctrl_t ctrl,
   input  wire logic [7:0]               snes_wdata,
   input  wire logic [7:0]               mcu_wdata,
   input  wire logic [15:0]              sram_rdata,
   output logic [15:0]                   sram_wdata,
   output logic [1:0]                    sram_be,
   output logic [7:0]                    snes_rdata,
   output logic [7:0]                    mcu_rdata
);

   ////////////////////
   // Byte registers
   ////////////////////

   logic [7:0] snes_in_mem;
   logic [7:0] mcu_in_mem;
   logic [7:0] snes_out_mem;
   logic [7:0] mcu_out_mem;

   logic [7:0] from_sram_byte;
   logic [7:0] to_sram_byte;

   // Odd addresses live in the high lane
   assign from_sram_byte = ctrl.byte_sel ? sram_rdata[15:8] : sram_rdata[7:0];

   // Write source follows the side that holds the grant
   assign to_sram_byte = ctrl.src_mcu ? mcu_in_mem : snes_in_mem;

   // Same byte on both lanes, enable picks the target
   assign sram_wdata = {to_sram_byte, to_sram_byte};
   assign sram_be    = ctrl.byte_sel ? 2'b10 : 2'b01;

   // Write-side captures
   always_ff @(posedge CLK) begin
      if (ctrl.snes_capture) begin
         snes_in_mem <= snes_wdata;
      end
      if (ctrl.mcu_capture) begin
         mcu_in_mem <= mcu_wdata;
      end
   end

   // Read-side captures from the SRAM word
   always_ff @(posedge CLK) begin
      if (reset) begin
         snes_out_mem <= 8'h00;
         mcu_out_mem  <= 8'h00;
      end else begin
         if (ctrl.sram_to_snes) begin
            snes_out_mem <= from_sram_byte;
         end
         if (ctrl.sram_to_mcu) begin
            mcu_out_mem <= from_sram_byte;
         end
      end
   end

   assign snes_rdata = snes_out_mem;
   assign mcu_rdata  = mcu_out_mem;

endmodule

`default_nettype wire

// ==== source/mem_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_sequencer (
   input  wire logic                                 CLK,
   input  wire logic                                 reset,
   input  wire cart_mem_pkg::snes_bus_in_t           snes,
   input  wire logic [cart_mem_pkg::SRAM_BYTE_AW-1:0] snes_byte_addr,
   input  wire cart_mem_pkg::region_e                region,
   input  wire mcu_reg_pkg::mcu_op_t                 mcu_op,
   output logic                                      mcu_done,
   output cart_mem_pkg::lane_ctrl_t                  lane,
   output logic [cart_mem_pkg::SRAM_WORD_AW-1:0]     sram_word_addr,
   output logic                                      sram_we,
   output logic                                      snes_oe
);

   cart_mem_pkg::seq_state_e state;
   cart_mem_pkg::seq_state_e state_nxt;

   mcu_reg_pkg::mcu_op_t pend_op;

   logic rd_q;
   logic wr_q;
   logic rd_edge;
   logic wr_edge;
   logic wr_step;
   logic grant_mcu;

   ////////////////////
   // Strobe edges
   ////////////////////

   assign rd_edge   = snes.rd && !rd_q;
   assign wr_edge   = snes.wr && !wr_q;
   assign grant_mcu = (state == cart_mem_pkg::S_MCU_RD) || (state == cart_mem_pkg::S_MCU_WR);

   ////////////////////
   // Next state
   ////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         cart_mem_pkg::S_IDLE, cart_mem_pkg::S_DONE: begin
            if (rd_edge) begin
               state_nxt = cart_mem_pkg::S_SNES_RD;
            end else if (wr_edge) begin
               state_nxt = cart_mem_pkg::S_SNES_WR;
            end else if (pend_op.valid) begin
               state_nxt = pend_op.is_write ? cart_mem_pkg::S_MCU_WR : cart_mem_pkg::S_MCU_RD;
            end else begin
               state_nxt = cart_mem_pkg::S_IDLE;
            end
         end
         // MCU access is one cycle, so a new SNES edge still makes cycle 1
         cart_mem_pkg::S_MCU_RD, cart_mem_pkg::S_MCU_WR: begin
            if (rd_edge) begin
               state_nxt = cart_mem_pkg::S_SNES_RD;
            end else if (wr_edge) begin
               state_nxt = cart_mem_pkg::S_SNES_WR;
            end else begin
               state_nxt = cart_mem_pkg::S_DONE;
            end
         end
         cart_mem_pkg::S_SNES_RD:    state_nxt = cart_mem_pkg::S_SNES_LATCH;
         cart_mem_pkg::S_SNES_LATCH: state_nxt = cart_mem_pkg::S_DONE;
         // Address setup first, then the write cycle
         cart_mem_pkg::S_SNES_WR: begin
            if (wr_step) begin
               state_nxt = cart_mem_pkg::S_DONE;
            end
         end
         default: state_nxt = cart_mem_pkg::S_IDLE;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (reset) begin
         state         <= cart_mem_pkg::S_IDLE;
         rd_q          <= 1'b0;
         wr_q          <= 1'b0;
         wr_step       <= 1'b0;
         pend_op.valid <= 1'b0;
      end else begin
         state   <= state_nxt;
         rd_q    <= snes.rd;
         wr_q    <= snes.wr;
         wr_step <= (state == cart_mem_pkg::S_SNES_WR) && !wr_step;
         // Single pending MCU slot
         if (mcu_op.valid) begin
            pend_op <= mcu_op;
         end else if (grant_mcu) begin
            pend_op.valid <= 1'b0;
         end
      end
   end

   ////////////////////
   // SRAM and lane control
   ////////////////////

   assign sram_word_addr = grant_mcu ? pend_op.addr[20:1]
                                     : snes_byte_addr[cart_mem_pkg::SRAM_BYTE_AW-1:1];

   assign sram_we = (state == cart_mem_pkg::S_MCU_WR) ||
                    ((state == cart_mem_pkg::S_SNES_WR) && wr_step &&
                     (region == cart_mem_pkg::REG_SAVE));

   assign mcu_done = grant_mcu;
   assign snes_oe  = snes.rd && (region != cart_mem_pkg::REG_NONE);

   always_comb begin
      lane.snes_capture = wr_edge;
      lane.mcu_capture  = mcu_op.valid && mcu_op.is_write;
      lane.sram_to_snes = (state == cart_mem_pkg::S_SNES_LATCH);
      lane.sram_to_mcu  = (state == cart_mem_pkg::S_MCU_RD);
      lane.byte_sel     = grant_mcu ? pend_op.addr[0] : snes_byte_addr[0];
      lane.src_mcu      = grant_mcu;
   end

endmodule

`default_nettype wire

// ==== source/mcu_axil_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcu_axil_port (
   input  wire logic                   CLK,
   input  wire logic                   reset,
   input  wire mcu_reg_pkg::axil_req_t axi,
   output mcu_reg_pkg::axil_resp_t     axi_resp,
   input  wire logic [7:0]             mcu_rdata,
   input  wire logic                   mcu_done,
   output mcu_reg_pkg::mcu_op_t        mcu_op,
   output logic [7:0]                  mcu_wdata,
   output cart_mem_pkg::map_mode_e     mode
);

   logic [20:0] addr_reg;
   logic [7:0]  data_reg;
   logic        busy;
   logic        bvalid;
   logic        rvalid;
   logic [31:0] rdata;
   logic        wr_fire;
   logic        rd_fire;

   mcu_reg_pkg::mcu_cmd_e cmd;

   // One outstanding transaction per channel
   assign wr_fire = axi.awvalid && axi.wvalid && !bvalid;
   assign rd_fire = axi.arvalid && !rvalid;
   assign cmd     = mcu_reg_pkg::mcu_cmd_e'(axi.wdata[7:0]);

   ////////////////////
   // Write channel
   ////////////////////

   always_ff @(posedge CLK) begin
      if (reset) begin
         bvalid       <= 1'b0;
         busy         <= 1'b0;
         mode         <= cart_mem_pkg::MAP_LOROM;
         mcu_op.valid <= 1'b0;
         addr_reg     <= '0;
      end else begin
         mcu_op.valid <= 1'b0;
         if (bvalid && axi.bready) begin
            bvalid <= 1'b0;
         end
         // Completion advances to the next byte
         if (mcu_done) begin
            busy     <= 1'b0;
            addr_reg <= addr_reg + 21'd1;
         end
         if (wr_fire) begin
            bvalid <= 1'b1;
            case (axi.awaddr)
               mcu_reg_pkg::REG_ADDR: addr_reg <= axi.wdata[20:0];
               mcu_reg_pkg::REG_DATA: data_reg <= axi.wdata[7:0];
               mcu_reg_pkg::REG_CMD: begin
                  if (!busy && (cmd == mcu_reg_pkg::CMD_READ ||
                                cmd == mcu_reg_pkg::CMD_WRITE)) begin
                     busy            <= 1'b1;
                     mcu_op.valid    <= 1'b1;
                     mcu_op.is_write <= (cmd == mcu_reg_pkg::CMD_WRITE);
                     mcu_op.addr     <= addr_reg;
                  end
               end
               mcu_reg_pkg::REG_CTRL: mode <= cart_mem_pkg::map_mode_e'(axi.wdata[0]);
               default: ;
            endcase
         end
      end
   end

   ////////////////////
   // Read channel
   ////////////////////

   always_ff @(posedge CLK) begin
      if (reset) begin
         rvalid <= 1'b0;
      end else begin
         if (rvalid && axi.rready) begin
            rvalid <= 1'b0;
         end
         if (rd_fire) begin
            rvalid <= 1'b1;
            case (axi.araddr)
               mcu_reg_pkg::REG_ADDR: rdata <= {11'd0, addr_reg};
               mcu_reg_pkg::REG_DATA: rdata <= {24'd0, mcu_rdata};
               mcu_reg_pkg::REG_CTRL: rdata <= {30'd0, busy, mode};
               default:               rdata <= 32'd0;
            endcase
         end
      end
   end

   assign mcu_wdata = data_reg;

   always_comb begin
      axi_resp.awready = wr_fire;
      axi_resp.wready  = wr_fire;
      axi_resp.bvalid  = bvalid;
      axi_resp.bresp   = mcu_reg_pkg::RESP_OKAY;
      axi_resp.arready = rd_fire;
      axi_resp.rvalid  = rvalid;
      axi_resp.rdata   = rdata;
      axi_resp.rresp   = mcu_reg_pkg::RESP_OKAY;
   end

endmodule

`default_nettype wire

// ==== source/cart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_top (
   input  wire logic                         CLK,
   input  wire logic                         reset,
   input  wire cart_mem_pkg::snes_bus_in_t   snes_in,
   output wire cart_mem_pkg::snes_bus_out_t  snes_out,
   input  wire mcu_reg_pkg::axil_req_t       axi,
   output wire mcu_reg_pkg::axil_resp_t      axi_resp,
   output wire cart_mem_pkg::sram_req_t      sram_req,
   input  wire logic [15:0]                  sram_rdata
);

   logic [cart_mem_pkg::SRAM_BYTE_AW-1:0] byte_addr;
   cart_mem_pkg::region_e                 region;
   cart_mem_pkg::map_mode_e               mode;
   cart_mem_pkg::lane_ctrl_t              lane;
   mcu_reg_pkg::mcu_op_t                  mcu_op;
   logic                                  mcu_done;
   logic [7:0]                            mcu_rdata;
   logic [7:0]                            mcu_wdata;

   snes_addr_map u_map (
      .addr      (snes_in.addr),
      .mode      (mode),
      .byte_addr (byte_addr),
      .region    (region)
   );

   // Sequencer owns address and write strobe of the SRAM request
   mem_sequencer u_seq (
      .CLK            (CLK),
      .reset          (reset),
      .snes           (snes_in),
      .snes_byte_addr (byte_addr),
      .region         (region),
      .mcu_op         (mcu_op),
      .mcu_done       (mcu_done),
      .lane           (lane),
      .sram_word_addr (sram_req.word_addr),
      .sram_we        (sram_req.we),
      .snes_oe        (snes_out.oe)
   );

   // Data path owns write data and lane enables
   byte_lane_data u_lanes (
      .CLK        (CLK),
      .reset      (reset),
      .ctrl       (lane),
      .snes_wdata (snes_in.data),
      .mcu_wdata  (mcu_wdata),
      .sram_rdata (sram_rdata),
      .sram_wdata (sram_req.wdata),
      .sram_be    (sram_req.be),
      .snes_rdata (snes_out.data),
      .mcu_rdata  (mcu_rdata)
   );

   mcu_axil_port u_host (
      .CLK       (CLK),
      .reset     (reset),
      .axi       (axi),
      .axi_resp  (axi_resp),
      .mcu_rdata (mcu_rdata),
      .mcu_done  (mcu_done),
      .mcu_op    (mcu_op),
      .mcu_wdata (mcu_wdata),
      .mode      (mode)
   );

endmodule

`default_nettype wire

// ==== dv/sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_model (
   input  wire logic                    CLK,
   input  wire cart_mem_pkg::sram_req_t req,
   output logic [15:0]                  rdata
);

   logic [15:0] mem [0:1048575];

   // Preload pattern built from every bit of the byte address
   function automatic logic [7:0] fill_byte(input logic [20:0] b);
      return b[7:0] ^ b[15:8] ^ {3'd0, b[20:16]} ^ 8'hA5;
   endfunction

   initial begin
      for (int i = 0; i < 1048576; i++) begin
         mem[i] = {fill_byte({i[19:0], 1'b1}), fill_byte({i[19:0], 1'b0})};
      end
   end

   // Asynchronous read port
   assign rdata = mem[req.word_addr];

   always_ff @(posedge CLK) begin
      if (req.we) begin
         if (req.be[0]) begin
            mem[req.word_addr][7:0] <= req.wdata[7:0];
         end
         if (req.be[1]) begin
            mem[req.word_addr][15:8] <= req.wdata[15:8];
         end
      end
   end

endmodule

`default_nettype wire

// ==== dv/tb_cart.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cart;

   localparam int MAX_CYCLES = 20000;

   logic CLK = 1'b0;
   logic reset;

   cart_mem_pkg::snes_bus_in_t  snes_in;
   cart_mem_pkg::snes_bus_out_t snes_out;
   mcu_reg_pkg::axil_req_t      axi;
   mcu_reg_pkg::axil_resp_t     axi_resp;
   cart_mem_pkg::sram_req_t     sram_req;
   logic [15:0]                 sram_rdata;

   logic [7:0]  shadow [0:2097151];
   logic [20:0] ptr;
   logic        hirom;
   integer      seed = 29852;
   int          cycles = 0;
   int          pass_count = 0;
   int          fail_count = 0;
   int          test_errs = 0;

   string       name_q[$];
   logic [31:0] exp_q[$];
   logic [31:0] act_q[$];
   string       cmp_name;
   logic [31:0] cmp_exp;
   logic [31:0] cmp_act;

   always #50 CLK = ~CLK;

   cart_top DUT (
      .CLK        (CLK),
      .reset      (reset),
      .snes_in    (snes_in),
      .snes_out   (snes_out),
      .axi        (axi),
      .axi_resp   (axi_resp),
      .sram_req   (sram_req),
      .sram_rdata (sram_rdata)
   );

   sram_model u_sram (
      .CLK   (CLK),
      .req   (sram_req),
      .rdata (sram_rdata)
   );

   ////////////////////
   // Reference model
   ////////////////////

   function automatic logic [7:0] fill_byte(input logic [20:0] b);
      return b[7:0] ^ b[15:8] ^ {3'd0, b[20:16]} ^ 8'hA5;
   endfunction

   // Region in bits 22:21 (0 none, 1 ROM, 2 save), byte address below
   function automatic logic [22:0] ref_map(input logic [23:0] a, input logic hi);
      logic [7:0]  bank;
      logic [22:0] res;
      bank = a[23:16];
      res  = 23'd0;
      if (!hi) begin
         if (bank >= 8'h70 && bank <= 8'h7D && !a[15]) begin
            res = {2'd2, 21'h1F8000 + {6'd0, a[14:0]}};
         end else if (a[15]) begin
            res = {2'd1, bank[5:0], a[14:0]};
         end
      end else begin
         if (bank >= 8'h20 && bank <= 8'h3F && a[15:0] >= 16'h6000 && a[15:0] <= 16'h7FFF) begin
            res = {2'd2, 21'h1F8000 + {8'd0, a[12:0]}};
         end else if (bank >= 8'hC0) begin
            res = {2'd1, bank[4:0], a[15:0]};
         end
      end
      return res;
   endfunction

   ////////////////////
   // Checking
   ////////////////////

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      name_q.push_back(name);
      exp_q.push_back(exp);
      act_q.push_back(act);
   endtask

   always @(negedge CLK) begin
      while (exp_q.size() > 0) begin
         cmp_name = name_q.pop_front();
         cmp_exp  = exp_q.pop_front();
         cmp_act  = act_q.pop_front();
         assert (cmp_exp == cmp_act) begin
            pass_count++;
         end else begin
            $display("Fail %s: expected %h, actual %h", cmp_name, cmp_exp, cmp_act);
            fail_count++;
            test_errs++;
         end
      end
   end

   task automatic end_test(input string name);
      @(negedge CLK);
      @(negedge CLK);
      $display("Test %s finished with %0d errors", name, test_errs);
      test_errs = 0;
   endtask

   // Hang guard
   always @(posedge CLK) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   ////////////////////
   // Bus tasks
   ////////////////////

   task automatic axi_write(input logic [3:0] a, input logic [31:0] d, input int stall);
      @(posedge CLK);
      axi.awaddr  <= a;
      axi.wdata   <= d;
      axi.awvalid <= 1'b1;
      axi.wvalid  <= 1'b1;
      axi.bready  <= (stall == 0);
      do @(negedge CLK); while (!axi_resp.awready);
      check("axi_wready", 32'd1, {31'd0, axi_resp.wready});
      @(posedge CLK);
      axi.awvalid <= 1'b0;
      axi.wvalid  <= 1'b0;
      do @(negedge CLK); while (!axi_resp.bvalid);
      check("axi_bresp", 32'd0, {30'd0, axi_resp.bresp});
      if (stall > 0) begin
         repeat (stall) @(posedge CLK);
         axi.bready <= 1'b1;
         @(negedge CLK);
         // Response still waiting after the stall
         check("axi_bvalid_hold", 32'd1, {31'd0, axi_resp.bvalid});
      end
      @(posedge CLK);
      axi.bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [3:0] a, output logic [31:0] d, input int stall);
      @(posedge CLK);
      axi.araddr  <= a;
      axi.arvalid <= 1'b1;
      axi.rready  <= (stall == 0);
      do @(negedge CLK); while (!axi_resp.arready);
      @(posedge CLK);
      axi.arvalid <= 1'b0;
      do @(negedge CLK); while (!axi_resp.rvalid);
      check("axi_rresp", 32'd0, {30'd0, axi_resp.rresp});
      if (stall > 0) begin
         repeat (stall) @(posedge CLK);
         axi.rready <= 1'b1;
         @(negedge CLK);
         check("axi_rvalid_hold", 32'd1, {31'd0, axi_resp.rvalid});
      end
      // Data taken in the handshake cycle
      d = axi_resp.rdata;
      @(posedge CLK);
      axi.rready <= 1'b0;
   endtask

   task automatic set_ptr(input logic [20:0] a);
      axi_write(mcu_reg_pkg::REG_ADDR, {11'd0, a}, 0);
      ptr = a;
   endtask

   task automatic wait_idle(input int stall);
      logic [31:0] v;
      do axi_read(mcu_reg_pkg::REG_CTRL, v, stall); while (v[1]);
   endtask

   task automatic mcu_write_byte(input logic [7:0] d, input int stall);
      axi_write(mcu_reg_pkg::REG_DATA, {24'd0, d}, stall);
      axi_write(mcu_reg_pkg::REG_CMD, 32'd2, stall);
      wait_idle(stall);
      shadow[ptr] = d;
      ptr = ptr + 21'd1;
   endtask

   task automatic mcu_read_check(input string name, input int stall);
      logic [31:0] v;
      logic [20:0] ea;
      ea = ptr;
      axi_write(mcu_reg_pkg::REG_CMD, 32'd1, stall);
      wait_idle(stall);
      axi_read(mcu_reg_pkg::REG_DATA, v, stall);
      check(name, {24'd0, shadow[ea]}, v);
      ptr = ptr + 21'd1;
   endtask

   task automatic snes_read_check(input string name, input logic [23:0] a);
      logic [22:0] m;
      logic [7:0]  d_early;
      logic [7:0]  d_late;
      logic        oe;
      m = ref_map(a, hirom);
      @(posedge CLK);
      snes_in.addr <= a;
      snes_in.rd   <= 1'b1;
      repeat (3) @(posedge CLK);
      @(negedge CLK);
      d_early = snes_out.data;
      repeat (2) @(posedge CLK);
      @(negedge CLK);
      d_late = snes_out.data;
      oe     = snes_out.oe;
      @(posedge CLK);
      snes_in.rd <= 1'b0;
      @(posedge CLK);
      check({name, "_oe"}, {31'd0, m[22:21] != 2'd0}, {31'd0, oe});
      if (m[22:21] != 2'd0) begin
         check({name, "_early"}, {24'd0, shadow[m[20:0]]}, {24'd0, d_early});
         check({name, "_late"}, {24'd0, shadow[m[20:0]]}, {24'd0, d_late});
      end
   endtask

   task automatic snes_write(input logic [23:0] a, input logic [7:0] d);
      logic [22:0] m;
      m = ref_map(a, hirom);
      @(posedge CLK);
      snes_in.addr <= a;
      snes_in.data <= d;
      snes_in.wr   <= 1'b1;
      repeat (6) @(posedge CLK);
      snes_in.wr <= 1'b0;
      @(posedge CLK);
      // Only save RAM takes SNES writes
      if (m[22:21] == 2'd2) begin
         shadow[m[20:0]] = d;
      end
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin
      logic [31:0] r;
      logic [31:0] v;
      logic [20:0] base;
      logic [23:0] a;
      logic [22:0] m;

      snes_in = '0;
      axi     = '0;
      reset   = 1'b1;
      hirom   = 1'b0;
      ptr     = '0;
      for (int i = 0; i < 2097152; i++) begin
         shadow[i] = fill_byte(i[20:0]);
      end
      repeat (10) @(posedge CLK);
      reset <= 1'b0;

      @(negedge CLK);
      check("reset_bvalid", 32'd0, {31'd0, axi_resp.bvalid});
      check("reset_rvalid", 32'd0, {31'd0, axi_resp.rvalid});
      check("reset_oe", 32'd0, {31'd0, snes_out.oe});
      check("reset_we", 32'd0, {31'd0, sram_req.we});
      axi_read(mcu_reg_pkg::REG_CTRL, v, 0);
      check("reset_ctrl", 32'd0, v);
      end_test("reset");

      // MCU burst with auto-increment
      r    = $random(seed);
      base = r[20:0];
      set_ptr(base);
      for (int i = 0; i < 8; i++) begin
         r = $random(seed);
         mcu_write_byte(r[7:0], 0);
      end
      axi_read(mcu_reg_pkg::REG_ADDR, v, 0);
      check("addr_incr", {11'd0, base + 21'd8}, v);
      set_ptr(base);
      for (int i = 0; i < 8; i++) begin
         mcu_read_check("mcu_readback", 0);
      end
      end_test("mcu_burst");

      for (int i = 0; i < 8; i++) begin
         r = $random(seed);
         snes_read_check("lorom_read", {r[23:16], 1'b1, r[14:0]});
      end
      end_test("lorom_read");

      axi_write(mcu_reg_pkg::REG_CTRL, 32'd1, 0);
      hirom = 1'b1;
      axi_read(mcu_reg_pkg::REG_CTRL, v, 0);
      check("ctrl_hirom", 32'd1, v);
      for (int i = 0; i < 6; i++) begin
         r = $random(seed);
         snes_read_check("hirom_rom", {2'b11, r[29:24], r[15:0]});
      end
      for (int i = 0; i < 4; i++) begin
         r = $random(seed);
         snes_read_check("hirom_save", {8'h20 + {3'd0, r[28:24]}, 3'b011, r[12:0]});
      end
      end_test("hirom_read");

      for (int i = 0; i < 4; i++) begin
         r = $random(seed);
         a = {8'h20 + {3'd0, r[28:24]}, 3'b011, r[12:0]};
         snes_write(a, r[23:16]);
         m = ref_map(a, hirom);
         set_ptr(m[20:0]);
         mcu_read_check("save_write", 0);
      end
      for (int i = 0; i < 4; i++) begin
         r = $random(seed);
         a = {2'b11, r[29:24], r[15:0]};
         snes_write(a, ~r[23:16]);
         snes_read_check("rom_write_ignored", a);
      end
      end_test("snes_write");

      for (int i = 0; i < 6; i++) begin
         r = $random(seed);
         snes_read_check("unmapped", {8'h40 + {1'b0, r[30:24]}, r[15:0]});
      end
      end_test("unmapped");

      // SNES traffic against stalled MCU commands
      r    = $random(seed);
      base = {1'b1, 4'd0, r[15:0]};
      fork
         begin
            set_ptr(base);
            for (int i = 0; i < 4; i++) begin
               r = $random(seed);
               mcu_write_byte(r[7:0], 3);
            end
            set_ptr(base);
            for (int i = 0; i < 4; i++) begin
               mcu_read_check("shared_mcu", 3);
            end
         end
         begin
            for (int i = 0; i < 8; i++) begin
               snes_read_check("shared_snes", {4'hC, i[3:0], base[15:0] ^ 16'(i * 97)});
               repeat (i % 3) @(posedge CLK);
            end
         end
      join
      wait_idle(0);
      axi_read(mcu_reg_pkg::REG_CTRL, v, 0);
      check("shared_idle", 32'd1, v);
      end_test("shared");

      $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
source/cart_mem_pkg.sv
source/mcu_reg_pkg.sv
source/snes_addr_map.sv
source/byte_lane_data.sv
source/mem_sequencer.sv
source/mcu_axil_port.sv
source/cart_top.sv
dv/sram_model.sv
dv/tb_cart.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' project.f)

.PHONY: run clean

run: obj_dir/Vtb_cart
	@out="$$(./obj_dir/Vtb_cart)"; echo "$$out"; echo "$$out" | grep -q '^STATUS: PASS$$'

obj_dir/Vtb_cart: project.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_cart -f project.f -o Vtb_cart

clean:
	rm -rf obj_dir
